/* list.f */
source/mcu_link_pkg.sv
source/sys_cfg_pkg.sv
source/sys_cmd_ctrl.sv
source/osd_cfg_bank.sv
source/board_io_regs.sv
source/irq_collector.sv
source/sys_ctrl_top.sv
verif/sys_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the system control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module sys_ctrl_tb -o sys_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sys_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

/* source/board_io_regs.sv */
// board LED register and RGB colour assembler
// colour bytes arrive bit reversed, green first

`timescale 1ns/100ps
`default_nettype none

module board_io_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    led_wr,
  input  logic                    color_wr,
  input  logic [1:0]              color_sel,
  input  mcu_link_pkg::mcu_byte_t wr_data,
  output logic [1:0]              leds,
  output sys_cfg_pkg::rgb_t       color
);

  import mcu_link_pkg::*;

  mcu_byte_t data_rev;

  // msb of the link byte becomes lsb of the colour field
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      data_rev[i] = wr_data[7 - i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // leds off, colour black
      leds  <= 2'b00;
      color <= '0;
    end else begin
      if (led_wr) begin
        leds <= wr_data[1:0];
      end
      if (color_wr) begin
        case (color_sel)
          2'd0: color[15:8]  <= data_rev;
          2'd1: color[7:0]   <= data_rev;
          2'd2: color[23:16] <= data_rev;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/irq_collector.sv */
// interrupt collector
// coldboot flag, interrupt request, acknowledge pulse and status byte

`timescale 1ns/100ps
`default_nettype none

module irq_collector (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [7:0]              int_in,
  input  logic                    ack_wr,
  input  mcu_link_pkg::mcu_byte_t wr_data,
  output logic [7:0]              int_ack,
  output logic                    int_out_n,
  output mcu_link_pkg::mcu_byte_t irq_status
);

  import mcu_link_pkg::*;

  // link byte of the previous cycle
  // ack_wr arrives one cycle after its strobe
  mcu_byte_t ack_byte;
  logic      coldboot;

  always_ff @(posedge clk) begin
    ack_byte <= wr_data;
  end

  // acknowledge byte shows only while ack_wr is high
  assign int_ack = ack_wr ? ack_byte : 8'h00;

  // reset is the power on event the MCU is told about
  always_ff @(posedge clk) begin
    if (reset) begin
      coldboot <= 1'b1;
    end else if (int_ack[0]) begin
      coldboot <= 1'b0;
    end
  end

  // bit 0 of the status carries coldboot in place of int_in[0]
  assign irq_status = {int_in[7:1], coldboot};

  // request stays low while anything is pending
  assign int_out_n = !((int_in != 8'h00) || coldboot);

  // one ack per irq command, commands need several strobes
  assert property (@(posedge clk) disable iff (reset)
    (int_ack != 8'h00) |=> (int_ack == 8'h00));

endmodule

`default_nettype wire

/* source/mcu_link_pkg.sv */
// MCU byte link definitions
// byte and index types, command codes, signature bytes, decoder states

`default_nettype none

package mcu_link_pkg;

  // one byte as carried over the MCU link
  typedef logic [7:0] mcu_byte_t;

  // position of a byte within a command, 1 is the first data byte
  typedef logic [3:0] byte_idx_t;

  // command codes sent in the start byte
  typedef enum logic [7:0] {
    cmd_status  = 8'd0,
    cmd_leds    = 8'd1,
    cmd_color   = 8'd2,
    cmd_buttons = 8'd3,
    cmd_config  = 8'd4,
    cmd_irq     = 8'd5
  } mcu_cmd_e;

  // decoder state
  // idle until the first start byte after reset
  typedef enum logic {
    idle,
    in_cmd
  } link_state_e;

  // identification pattern, unlikely to come from a blank device
  localparam mcu_byte_t sig_byte0 = 8'h5c;
  localparam mcu_byte_t sig_byte1 = 8'h42;

endpackage

`default_nettype wire

/* source/osd_cfg_bank.sv */
// user configuration register bank
// id byte latch and ten settings written by id match

`timescale 1ns/100ps
`default_nettype none

module osd_cfg_bank (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cfg_id_wr,
  input  logic                    cfg_val_wr,
  input  mcu_link_pkg::mcu_byte_t wr_data,
  output sys_cfg_pkg::cfg2_t      system_reset,
  output sys_cfg_pkg::cfg2_t      system_scanlines,
  output sys_cfg_pkg::cfg2_t      system_volume,
  output logic                    system_wide_screen,
  output sys_cfg_pkg::cfg4_t      system_port_1,
  output sys_cfg_pkg::cfg4_t      system_port_2,
  output sys_cfg_pkg::cfg2_t      system_turbo_mode,
  output sys_cfg_pkg::cfg3_t      system_sid_mode,
  output logic                    system_pause,
  output logic                    system_georam
);

  import mcu_link_pkg::*;
  import sys_cfg_pkg::*;

  // id of the setting the next value goes to
  mcu_byte_t cfg_id;

  always_ff @(posedge clk) begin
    if (cfg_id_wr) begin
      cfg_id <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      system_reset       <= cfg_reset_default;
      system_scanlines   <= cfg_scanlines_default;
      system_volume      <= cfg_volume_default;
      system_wide_screen <= cfg_wide_screen_default;
      system_port_1      <= cfg_port_1_default;
      system_port_2      <= cfg_port_2_default;
      system_turbo_mode  <= cfg_turbo_mode_default;
      system_sid_mode    <= cfg_sid_mode_default;
      system_pause       <= cfg_pause_default;
      system_georam      <= cfg_georam_default;
    end else if (cfg_val_wr) begin
      // only the low bits of the value byte are kept
      case (cfg_id)
        // run, reset or coldboot
        cfg_id_reset:       system_reset       <= wr_data[1:0];
        // scanline strength in 25% steps
        cfg_id_scanlines:   system_scanlines   <= wr_data[1:0];
        cfg_id_volume:      system_volume      <= wr_data[1:0];
        // 4:3 or 16:9
        cfg_id_wide_screen: system_wide_screen <= wr_data[0];
        // joystick input device per port
        cfg_id_port_1:      system_port_1      <= wr_data[3:0];
        cfg_id_port_2:      system_port_2      <= wr_data[3:0];
        cfg_id_turbo_mode:  system_turbo_mode  <= wr_data[1:0];
        cfg_id_sid_mode:    system_sid_mode    <= wr_data[2:0];
        // pause the machine while the OSD is open
        cfg_id_pause:       system_pause       <= wr_data[0];
        cfg_id_georam:      system_georam      <= wr_data[0];
        // unknown id, nothing to write
        default: ;
      endcase
    end
  end

  // the id latched at an edge is only used from the next strobe on
  assert property (@(posedge clk) disable iff (reset)
    cfg_id_wr |=> !cfg_val_wr);

endmodule

`default_nettype wire

/* source/sys_cfg_pkg.sv */
// user configuration definitions
// setting id characters, setting widths, colour type and reset defaults

`default_nettype none

package sys_cfg_pkg;

  // setting widths
  typedef logic [1:0]  cfg2_t;
  typedef logic [2:0]  cfg3_t;
  typedef logic [3:0]  cfg4_t;

  // rgb colour, red in the top byte
  typedef logic [23:0] rgb_t;

  // id characters, sent as the first data byte of the config command
  localparam mcu_link_pkg::mcu_byte_t cfg_id_reset       = "R";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_scanlines   = "S";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_volume      = "A";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_wide_screen = "W";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_port_1      = "Q";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_port_2      = "J";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_turbo_mode  = "X";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_sid_mode    = "K";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_pause       = "G";
  localparam mcu_link_pkg::mcu_byte_t cfg_id_georam      = "#";

  // reset defaults, the MCU normally overrides these shortly after boot
  // run mode
  localparam cfg2_t cfg_reset_default       = 2'd0;
  localparam cfg2_t cfg_scanlines_default   = 2'd0;
  // volume at 66%
  localparam cfg2_t cfg_volume_default      = 2'd2;
  localparam logic  cfg_wide_screen_default = 1'b0;
  // port 1 off
  localparam cfg4_t cfg_port_1_default      = 4'd7;
  localparam cfg4_t cfg_port_2_default      = 4'd0;
  localparam cfg2_t cfg_turbo_mode_default  = 2'd0;
  localparam cfg3_t cfg_sid_mode_default    = 3'd0;
  localparam logic  cfg_pause_default       = 1'b0;
  localparam logic  cfg_georam_default      = 1'b0;

endpackage

`default_nettype wire

/* source/sys_cmd_ctrl.sv */
// MCU command decoder
// tracks command and byte index, issues datapath write pulses, drives reply byte

`timescale 1ns/100ps
`default_nettype none

module sys_cmd_ctrl #(
  parameter mcu_link_pkg::mcu_byte_t core_id = 8'd2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    data_in_strobe,
  input  logic                    data_in_start,
  input  mcu_link_pkg::mcu_byte_t data_in,
  input  logic [1:0]              buttons,
  input  mcu_link_pkg::mcu_byte_t irq_status,
  output mcu_link_pkg::mcu_byte_t data_out,
  output logic                    led_wr,
  output logic                    color_wr,
  output logic [1:0]              color_sel,
  output logic                    cfg_id_wr,
  output logic                    cfg_val_wr,
  output logic                    ack_wr,
  output mcu_link_pkg::mcu_byte_t wr_data
);

  import mcu_link_pkg::*;

  link_state_e state;
  mcu_cmd_e    command;
  byte_idx_t   byte_idx;
  logic        data_valid;

  // a data byte only counts once a command is open
  assign data_valid = data_in_strobe && !data_in_start && (state == in_cmd);

  // datapath blocks take the byte straight from the link
  assign wr_data = data_in;

  // command and index tracking
  // a start byte always restarts, even mid command
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      command  <= cmd_status;
      byte_idx <= '0;
    end else if (data_in_strobe) begin
      if (data_in_start) begin
        state    <= in_cmd;
        command  <= mcu_cmd_e'(data_in);
        byte_idx <= 4'd1;
      end else if (state == in_cmd && byte_idx != 4'd15) begin
        // saturate so long commands keep the last index
        byte_idx <= byte_idx + 4'd1;
      end
    end
  end

  // write pulses, valid in the strobe cycle itself
  always_comb begin
    led_wr     = 1'b0;
    color_wr   = 1'b0;
    color_sel  = 2'd0;
    cfg_id_wr  = 1'b0;
    cfg_val_wr = 1'b0;
    if (data_valid) begin
      case (command)
        cmd_leds: led_wr = (byte_idx == 4'd1);
        cmd_color: begin
          // green, blue, red in that order
          case (byte_idx)
            4'd1: begin
              color_wr  = 1'b1;
              color_sel = 2'd0;
            end
            4'd2: begin
              color_wr  = 1'b1;
              color_sel = 2'd1;
            end
            4'd3: begin
              color_wr  = 1'b1;
              color_sel = 2'd2;
            end
            default: ;
          endcase
        end
        cmd_config: begin
          // id character first, then the value
          cfg_id_wr  = (byte_idx == 4'd1);
          cfg_val_wr = (byte_idx == 4'd2);
        end
        default: ;
      endcase
    end
  end

  // reply byte and registered acknowledge pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
      ack_wr   <= 1'b0;
    end else begin
      // ack only on the first data byte of the irq command
      ack_wr <= data_valid && (command == cmd_irq) && (byte_idx == 4'd1);
      if (data_valid) begin
        case (command)
          cmd_status: begin
            // later bytes leave the reply at core_id
            case (byte_idx)
              4'd1: data_out <= sig_byte0;
              4'd2: data_out <= sig_byte1;
              4'd3: data_out <= core_id;
              default: ;
            endcase
          end
          cmd_buttons: data_out <= {6'b000000, buttons};
          // status is sampled before any ack of this byte takes effect
          cmd_irq: data_out <= irq_status;
          default: ;
        endcase
      end
    end
  end

  // registered ack must not overlap a combinational pulse of the next byte
  assert property (@(posedge clk) disable iff (reset)
    $onehot0({led_wr, color_wr, cfg_id_wr, cfg_val_wr, ack_wr}));

endmodule

`default_nettype wire

/* source/sys_ctrl_top.sv */
// system control top level
// MCU command decoder with config bank, board I/O and interrupt blocks

`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_top #(
  parameter mcu_link_pkg::mcu_byte_t core_id = 8'd2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    data_in_strobe,
  input  logic                    data_in_start,
  input  mcu_link_pkg::mcu_byte_t data_in,
  output mcu_link_pkg::mcu_byte_t data_out,
  input  logic [1:0]              buttons,
  input  logic [7:0]              int_in,
  output logic                    int_out_n,
  output logic [7:0]              int_ack,
  output logic [1:0]              leds,
  output sys_cfg_pkg::rgb_t       color,
  output sys_cfg_pkg::cfg2_t      system_reset,
  output sys_cfg_pkg::cfg2_t      system_scanlines,
  output sys_cfg_pkg::cfg2_t      system_volume,
  output logic                    system_wide_screen,
  output sys_cfg_pkg::cfg4_t      system_port_1,
  output sys_cfg_pkg::cfg4_t      system_port_2,
  output sys_cfg_pkg::cfg2_t      system_turbo_mode,
  output sys_cfg_pkg::cfg3_t      system_sid_mode,
  output logic                    system_pause,
  output logic                    system_georam
);

  import mcu_link_pkg::*;

  // decoder to datapath
  logic       led_wr;
  logic       color_wr;
  logic [1:0] color_sel;
  logic       cfg_id_wr;
  logic       cfg_val_wr;
  logic       ack_wr;
  mcu_byte_t  wr_data;
  // status back into the decoder reply
  mcu_byte_t  irq_status;

  sys_cmd_ctrl #(
    .core_id (core_id)
  ) u_cmd_ctrl (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .data_in_start  (data_in_start),
    .data_in        (data_in),
    .buttons        (buttons),
    .irq_status     (irq_status),
    .data_out       (data_out),
    .led_wr         (led_wr),
    .color_wr       (color_wr),
    .color_sel      (color_sel),
    .cfg_id_wr      (cfg_id_wr),
    .cfg_val_wr     (cfg_val_wr),
    .ack_wr         (ack_wr),
    .wr_data        (wr_data)
  );

  osd_cfg_bank u_cfg_bank (
    .clk                (clk),
    .reset              (reset),
    .cfg_id_wr          (cfg_id_wr),
    .cfg_val_wr         (cfg_val_wr),
    .wr_data            (wr_data),
    .system_reset       (system_reset),
    .system_scanlines   (system_scanlines),
    .system_volume      (system_volume),
    .system_wide_screen (system_wide_screen),
    .system_port_1      (system_port_1),
    .system_port_2      (system_port_2),
    .system_turbo_mode  (system_turbo_mode),
    .system_sid_mode    (system_sid_mode),
    .system_pause       (system_pause),
    .system_georam      (system_georam)
  );

  board_io_regs u_board_io (
    .clk       (clk),
    .reset     (reset),
    .led_wr    (led_wr),
    .color_wr  (color_wr),
    .color_sel (color_sel),
    .wr_data   (wr_data),
    .leds      (leds),
    .color     (color)
  );

  irq_collector u_irq (
    .clk        (clk),
    .reset      (reset),
    .int_in     (int_in),
    .ack_wr     (ack_wr),
    .wr_data    (wr_data),
    .int_ack    (int_ack),
    .int_out_n  (int_out_n),
    .irq_status (irq_status)
  );

endmodule

`default_nettype wire

/* verif/sys_ctrl_tb.sv */
// testbench for the system control block
// MCU byte driver, reference model, output checker and test sequence

`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_tb;

  import mcu_link_pkg::*;
  import sys_cfg_pkg::*;

  // the sequence below runs for about 4400 cycles
  localparam int timeout_cycles = 20000;
  localparam mcu_byte_t core_id = 8'd2;
  localparam int n_btn = 40;
  localparam int n_led = 100;
  localparam int n_color = 100;
  localparam int n_cfg = 300;
  localparam int n_irq = 100;

  // DUT ports connected by name
  logic       clk;
  logic       reset;
  logic       data_in_strobe;
  logic       data_in_start;
  mcu_byte_t  data_in;
  mcu_byte_t  data_out;
  logic [1:0] buttons;
  logic [7:0] int_in;
  logic       int_out_n;
  logic [7:0] int_ack;
  logic [1:0] leds;
  rgb_t       color;
  cfg2_t      system_reset;
  cfg2_t      system_scanlines;
  cfg2_t      system_volume;
  logic       system_wide_screen;
  cfg4_t      system_port_1;
  cfg4_t      system_port_2;
  cfg2_t      system_turbo_mode;
  cfg3_t      system_sid_mode;
  logic       system_pause;
  logic       system_georam;

  // model state
  logic       m_open;
  mcu_byte_t  m_cmd;
  byte_idx_t  m_idx;
  mcu_byte_t  m_cfg_id;
  mcu_byte_t  known_ids [10];
  // expected outputs
  mcu_byte_t  exp_reply;
  mcu_byte_t  exp_ack;
  logic       exp_coldboot;
  logic [1:0] exp_leds;
  rgb_t       exp_color;
  cfg2_t      exp_reset;
  cfg2_t      exp_scanlines;
  cfg2_t      exp_volume;
  logic       exp_wide_screen;
  cfg4_t      exp_port_1;
  cfg4_t      exp_port_2;
  cfg2_t      exp_turbo_mode;
  cfg3_t      exp_sid_mode;
  logic       exp_pause;
  logic       exp_georam;

  logic       compare_en;
  int         cycles = 0;
  integer     seed = 32'hce6b_98d2;

  sys_ctrl_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout: test sequence still running after %0d cycles", timeout_cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic mcu_byte_t random_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic mcu_byte_t bit_reverse(input mcu_byte_t b);
    return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
  endfunction

  // state right after reset
  task automatic init_model();
    m_open          = 1'b0;
    m_cmd           = 8'h00;
    m_idx           = 4'd0;
    m_cfg_id        = 8'h00;
    exp_reply       = 8'h00;
    exp_ack         = 8'h00;
    exp_coldboot    = 1'b1;
    exp_leds        = 2'b00;
    exp_color       = 24'h000000;
    exp_reset       = 2'd0;
    exp_scanlines   = 2'd0;
    exp_volume      = 2'd2;
    exp_wide_screen = 1'b0;
    exp_port_1      = 4'd7;
    exp_port_2      = 4'd0;
    exp_turbo_mode  = 2'd0;
    exp_sid_mode    = 3'd0;
    exp_pause       = 1'b0;
    exp_georam      = 1'b0;
    known_ids = '{cfg_id_reset, cfg_id_scanlines, cfg_id_volume, cfg_id_wide_screen,
                  cfg_id_port_1, cfg_id_port_2, cfg_id_turbo_mode, cfg_id_sid_mode,
                  cfg_id_pause, cfg_id_georam};
  endtask

  // reference model of one link byte
  // updates the expected state and returns the expected reply
  function automatic mcu_byte_t model_byte(input mcu_byte_t b, input logic start);
    mcu_byte_t reply;
    reply = exp_reply;
    if (start) begin
      m_open = 1'b1;
      m_cmd  = b;
      m_idx  = 4'd1;
    end else if (m_open) begin
      case (m_cmd)
        cmd_status: begin
          case (m_idx)
            4'd1: reply = 8'h5c;
            4'd2: reply = 8'h42;
            4'd3: reply = core_id;
            default: ;
          endcase
        end
        cmd_leds: if (m_idx == 4'd1) exp_leds = b[1:0];
        cmd_color: begin
          // green, blue, red
          case (m_idx)
            4'd1: exp_color[15:8] = bit_reverse(b);
            4'd2: exp_color[7:0] = bit_reverse(b);
            4'd3: exp_color[23:16] = bit_reverse(b);
            default: ;
          endcase
        end
        cmd_buttons: reply = {6'd0, buttons};
        cmd_config: begin
          if (m_idx == 4'd1) m_cfg_id = b;
          if (m_idx == 4'd2) begin
            case (m_cfg_id)
              cfg_id_reset:       exp_reset = b[1:0];
              cfg_id_scanlines:   exp_scanlines = b[1:0];
              cfg_id_volume:      exp_volume = b[1:0];
              cfg_id_wide_screen: exp_wide_screen = b[0];
              cfg_id_port_1:      exp_port_1 = b[3:0];
              cfg_id_port_2:      exp_port_2 = b[3:0];
              cfg_id_turbo_mode:  exp_turbo_mode = b[1:0];
              cfg_id_sid_mode:    exp_sid_mode = b[2:0];
              cfg_id_pause:       exp_pause = b[0];
              cfg_id_georam:      exp_georam = b[0];
              default: ;
            endcase
          end
        end
        cmd_irq: begin
          // status still shows coldboot as it was before this ack
          reply = (int_in & 8'hfe) | {7'd0, exp_coldboot};
          if (m_idx == 4'd1) exp_ack = b;
        end
        default: ;
      endcase
      if (m_idx != 4'd15) m_idx = m_idx + 4'd1;
    end
    return reply;
  endfunction

  // checker compares all outputs once per cycle at the falling edge
  always @(negedge clk) begin
    if (compare_en) begin
      compare_value("data_out", 32'(data_out), 32'(exp_reply));
      compare_value("int_ack", 32'(int_ack), 32'(exp_ack));
      compare_value("int_out_n", 32'(int_out_n), 32'((int_in == 8'h00) && !exp_coldboot));
      compare_value("leds", 32'(leds), 32'(exp_leds));
      compare_value("color", 32'(color), 32'(exp_color));
      compare_value("system_reset", 32'(system_reset), 32'(exp_reset));
      compare_value("system_scanlines", 32'(system_scanlines), 32'(exp_scanlines));
      compare_value("system_volume", 32'(system_volume), 32'(exp_volume));
      compare_value("system_wide_screen", 32'(system_wide_screen), 32'(exp_wide_screen));
      compare_value("system_port_1", 32'(system_port_1), 32'(exp_port_1));
      compare_value("system_port_2", 32'(system_port_2), 32'(exp_port_2));
      compare_value("system_turbo_mode", 32'(system_turbo_mode), 32'(exp_turbo_mode));
      compare_value("system_sid_mode", 32'(system_sid_mode), 32'(exp_sid_mode));
      compare_value("system_pause", 32'(system_pause), 32'(exp_pause));
      compare_value("system_georam", 32'(system_georam), 32'(exp_georam));
      // ack lasts one cycle and bit 0 clears coldboot at the following edge
      if (exp_ack[0]) exp_coldboot = 1'b0;
      exp_ack = 8'h00;
    end
  end

  // one strobe followed by one idle cycle
  // the model steps at the edge that ends the strobe
  task automatic send_byte(input mcu_byte_t b, input logic start);
    @(posedge clk);
    data_in        <= b;
    data_in_start  <= start;
    data_in_strobe <= 1'b1;
    @(posedge clk);
    data_in_strobe <= 1'b0;
    data_in_start  <= 1'b0;
    exp_reply = model_byte(b, start);
    @(negedge clk);
  endtask

  task automatic identify_core();
    mcu_byte_t r;
    send_byte(cmd_status, 1'b1);
    repeat (4) send_byte(random_byte(), 1'b0);
    // in a long command the index saturates and the reply stays at core_id
    send_byte(cmd_status, 1'b1);
    repeat (18) send_byte(random_byte(), 1'b0);
    for (int k = 0; k < n_btn; k++) begin
      r = random_byte();
      @(posedge clk);
      buttons <= r[1:0];
      send_byte(cmd_buttons, 1'b1);
      repeat (3) send_byte(random_byte(), 1'b0);
    end
  endtask

  task automatic drive_board_io();
    for (int k = 0; k < n_led; k++) begin
      send_byte(cmd_leds, 1'b1);
      send_byte(random_byte(), 1'b0);
    end
    for (int k = 0; k < n_color; k++) begin
      send_byte(cmd_color, 1'b1);
      // now and then restart in the middle of a colour
      if (k % 4 == 3) begin
        send_byte(random_byte(), 1'b0);
        send_byte(cmd_color, 1'b1);
      end
      repeat (3) send_byte(random_byte(), 1'b0);
    end
  endtask

  task automatic write_config();
    mcu_byte_t r;
    mcu_byte_t id;
    for (int k = 0; k < n_cfg; k++) begin
      r = random_byte();
      // mostly known ids and otherwise any byte
      if (r[3:0] < 4'd10) id = known_ids[r[3:0]];
      else id = random_byte();
      send_byte(cmd_config, 1'b1);
      send_byte(id, 1'b0);
      send_byte(random_byte(), 1'b0);
    end
  endtask

  task automatic service_interrupts();
    mcu_byte_t r;
    mcu_byte_t ack;
    for (int k = 0; k < n_irq; k++) begin
      r = random_byte();
      @(posedge clk);
      // int_in quiet at times so coldboot alone drives the request
      int_in <= (r[7:5] == 3'd0) ? 8'h00 : random_byte();
      ack = random_byte();
      // keep coldboot pending through the first half
      if (k < n_irq / 2) ack[0] = 1'b0;
      send_byte(cmd_irq, 1'b1);
      send_byte(ack, 1'b0);
      send_byte(random_byte(), 1'b0);
    end
    @(posedge clk);
    int_in <= 8'h00;
    send_byte(cmd_irq, 1'b1);
    send_byte(8'h01, 1'b0);
    send_byte(random_byte(), 1'b0);
    // nothing pending any more
    compare_value("int_out_n", 32'(int_out_n), 32'd1);
  endtask

  task automatic send_unknown_commands();
    mcu_byte_t code;
    for (int k = 0; k < 20; k++) begin
      code = random_byte();
      if (code < 8'd6) code = code + 8'd6;
      send_byte(code, 1'b1);
      repeat (4) send_byte(random_byte(), 1'b0);
    end
  endtask

  initial begin
    reset          = 1'b1;
    data_in_strobe = 1'b0;
    data_in_start  = 1'b0;
    data_in        = 8'h00;
    buttons        = 2'b00;
    int_in         = 8'h00;
    compare_en     = 1'b0;
    init_model();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    compare_en = 1'b1;
    // data bytes before any start byte are ignored
    repeat (6) send_byte(random_byte(), 1'b0);
    identify_core();
    drive_board_io();
    write_config();
    service_interrupts();
    send_unknown_commands();
    repeat (4) @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
